//--- hw/neo_cart_defs.svh
`ifndef NEO_CART_DEFS_SVH
`define NEO_CART_DEFS_SVH

// ioctl byte address
`define NEO_ADDR_W      27

// .NEO header layout
`define NEO_HDR_BYTES   4096
`define NEO_SIZE_FIRST  4
`define NEO_SIZE_LAST   27

// Download block, the buffer holds two
`define NEO_BLOCK       128

// Bank 3 prefixes on byte address bits 23:19
`define NEO_FIX_BASE    5'b11100
`define NEO_M_BASE      5'b11110

`endif

//--- hw/neo_cart_pkg.sv
`default_nettype none

`include "neo_cart_defs.svh"

package neo_cart_pkg;

	typedef enum logic [2:0] {
		REG_P    = 3'd0,
		REG_S    = 3'd1,
		REG_M    = 3'd2,
		REG_V1   = 3'd3,
		REG_V2   = 3'd4,
		REG_C    = 3'd5,
		REG_DONE = 3'd6
	} region_e;

	typedef struct packed {
		logic                   downl;
		logic                   wr;
		logic [`NEO_ADDR_W-1:0] addr;
		logic [7:0]             dout;
	} ioctl_t;

	// Header order, P sits in the low word
	typedef struct packed {
		logic [31:0] c;
		logic [31:0] v2;
		logic [31:0] v1;
		logic [31:0] m;
		logic [31:0] s;
		logic [31:0] p;
	} sizes_t;

	typedef struct packed {
		logic        req;
		logic [22:0] addr;
		logic [15:0] data;
	} p1_wr_t;

	typedef struct packed {
		logic        req;
		logic [24:0] addr;
		logic [15:0] data;
	} p2_wr_t;

	typedef struct packed {
		logic [1:0] tile;   // bits 6:5
		logic       col;
		logic       half;
		logic [2:0] row;
	} fix_idx_t;

	typedef struct packed {
		logic       plane_hi;   // bit 6
		logic [3:0] line;
		logic       plane_lo;
		logic       lsb;
	} spr_idx_t;

	typedef union packed {
		logic [6:0] raw;
		fix_idx_t   fix;
		spr_idx_t   spr;
	} blk_idx_u;

endpackage

`default_nettype wire

//--- hw/sdram_addr_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "neo_cart_defs.svh"

module sdram_addr_map (
	input  wire neo_cart_pkg::region_e region,
	input  wire [`NEO_ADDR_W-1:0]      offset,
	input  wire neo_cart_pkg::sizes_t  sizes,
	input  wire                        pcm_merged,
	output logic [22:0]                p1_addr,
	output logic [24:0]                p2_addr
);
	import neo_cart_pkg::*;

	logic [23:0] b1;   // bank 3 byte address
	logic [31:0] b2;
	logic [31:0] v2_base;

	// Samples follow the sprites, V2 after V1
	assign v2_base = sizes.c + sizes.v1;

	always_comb begin
		case (region)
			REG_S:   b1 = {`NEO_FIX_BASE, offset[18:0]};
			REG_M:   b1 = {`NEO_M_BASE, offset[18:0]};
			default: b1 = offset[23:0];
		endcase
		case (region)
			REG_V1:  b2 = sizes.c + 32'(offset);
			REG_V2:  b2 = v2_base + 32'(offset);
			default: b2 = 32'(offset);   // C from the bottom
		endcase
	end

	assign p1_addr = b1[23:1];
	assign p2_addr = b2[25:1];

endmodule

`default_nettype wire

//--- hw/neo_header.sv
`timescale 1ns/1ps
`default_nettype none

`include "neo_cart_defs.svh"

module neo_header (
	input  wire                        CLK_48M,
	input  wire                        pll_locked,
	input  wire neo_cart_pkg::ioctl_t  ioctl,
	input  wire neo_cart_pkg::region_e region,
	output neo_cart_pkg::sizes_t       sizes,
	output logic [31:0]                region_size,
	output logic                       pcm_merged
);
	import neo_cart_pkg::*;

	logic hdr_wr;
	logic size_byte;

	assign hdr_wr    = ioctl.downl && ioctl.wr && ioctl.addr < `NEO_HDR_BYTES;
	assign size_byte = ioctl.addr >= `NEO_SIZE_FIRST && ioctl.addr <= `NEO_SIZE_LAST;

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			sizes <= '0;
			pcm_merged <= 1'b0;
		end else if (hdr_wr) begin
			if (size_byte)
				sizes <= {ioctl.dout, sizes[$bits(sizes_t)-1:8]};   // LE chain, P first
			// Neobuilder packs ADPCM-A and B together when V2 is empty
			if (ioctl.addr == `NEO_HDR_BYTES - 1)
				pcm_merged <= sizes.v2 == 32'd0;
		end
	end

	always_comb begin
		case (region)
			REG_P:   region_size = sizes.p;
			REG_S:   region_size = sizes.s;
			REG_M:   region_size = sizes.m;
			REG_V1:  region_size = sizes.v1;
			REG_V2:  region_size = sizes.v2;
			REG_C:   region_size = sizes.c;
			default: region_size = 32'd0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/tile_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "neo_cart_defs.svh"

module tile_fifo (
	input  wire                        CLK_48M,
	input  wire                        pll_locked,
	input  wire neo_cart_pkg::ioctl_t  ioctl,
	input  wire                        fill_en,
	input  wire neo_cart_pkg::region_e region,
	input  wire [5:0]                  rd_idx,
	output logic                       page_full,
	output logic [15:0]                rd_data
);
	import neo_cart_pkg::*;

	logic [1:0][7:0] mem [`NEO_BLOCK];   // 2 pages x 64 words
	blk_idx_u        src;
	logic [6:0]      dst;
	logic            fill_wr;
	logic            page;
	logic            rd_busy;
	logic [5:0]      rd_idx_q;

	assign src.raw = ioctl.addr[6:0];
	assign fill_wr = ioctl.wr && fill_en;

	// Tile shuffle within the block
	always_comb begin
		case (region)
			REG_S:   dst = {src.fix.tile, src.fix.row, ~src.fix.col, src.fix.half};
			REG_C:   dst = {src.spr.line, ~src.spr.plane_hi, src.spr.lsb, src.spr.plane_lo};
			default: dst = src.raw;
		endcase
	end

	always_ff @(posedge CLK_48M) begin
		if (fill_wr)
			mem[{page, dst[6:1]}][dst[0]] <= ioctl.dout;
		rd_data <= mem[{~page, rd_idx}];   // Drain side is the other page
	end

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			page <= 1'b0;
			page_full <= 1'b0;
			rd_busy <= 1'b0;
			rd_idx_q <= 6'd0;
		end else begin
			page_full <= 1'b0;
			rd_idx_q <= rd_idx;
			if (rd_idx_q == 6'd63 && rd_idx == 6'd0)
				rd_busy <= 1'b0;
			if (fill_wr && &ioctl.addr[6:0]) begin
				page <= ~page;
				page_full <= 1'b1;
				rd_busy <= 1'b1;
			end
		end
	end

	a_no_overrun: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		fill_wr && &ioctl.addr[6:0] |-> !rd_busy);

endmodule

`default_nettype wire

//--- hw/load_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "neo_cart_defs.svh"

module load_ctrl (
	input  wire                       CLK_48M,
	input  wire                       pll_locked,
	input  wire neo_cart_pkg::ioctl_t ioctl,
	input  wire [31:0]                region_size,
	input  wire                       page_full,
	input  wire [15:0]                rd_data,
	input  wire [22:0]                p1_addr,
	input  wire [24:0]                p2_addr,
	input  wire                       p1_ack,
	input  wire                       p2_ack,
	output neo_cart_pkg::region_e     region,
	output logic [`NEO_ADDR_W-1:0]    offset,
	output logic                      fill_en,
	output logic [5:0]                rd_idx,
	output neo_cart_pkg::p1_wr_t      p1_wr,
	output neo_cart_pkg::p2_wr_t      p2_wr
);
	import neo_cart_pkg::*;

	logic        hdr_done;
	logic        blk_last;
	logic        region_end;
	logic        busy;
	logic        pend;
	logic        drain_p2;
	logic        ack_ok;
	logic        p1_req;
	logic        p2_req;
	logic [24:0] wr_addr;
	logic [15:0] wr_data;

	assign fill_en    = ioctl.downl && hdr_done && region != REG_DONE;
	assign blk_last   = ioctl.wr && fill_en && &ioctl.addr[6:0];
	assign region_end = hdr_done && region != REG_DONE && 32'(offset) == region_size;
	assign ack_ok     = drain_p2 ? p2_req == p2_ack : p1_req == p1_ack;

	// Region sequencer on the incoming byte stream
	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			hdr_done <= 1'b0;
			region <= REG_P;
			offset <= '0;
		end else if (!ioctl.downl) begin
			hdr_done <= 1'b0;
			region <= REG_P;
			offset <= '0;
		end else if (!hdr_done) begin
			if (ioctl.wr && ioctl.addr == `NEO_HDR_BYTES - 1)
				hdr_done <= 1'b1;
		end else if (region_end) begin
			region <= region_e'(region + 3'd1);   // Empty regions pass one per cycle
			offset <= '0;
		end else if (ioctl.wr && fill_en) begin
			offset <= offset + 1'b1;
		end
	end

	// Drain of the full page, one toggle per word
	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			busy <= 1'b0;
			pend <= 1'b0;
			drain_p2 <= 1'b0;
			rd_idx <= 6'd0;
			p1_req <= 1'b0;
			p2_req <= 1'b0;
		end else begin
			if (page_full)
				busy <= 1'b1;
			if (blk_last)
				drain_p2 <= region >= REG_V1;
			if (pend && ack_ok) begin
				pend <= 1'b0;
				if (rd_idx == 6'd0)
					busy <= 1'b0;   // Word 63 acked
			end else if (busy && !pend) begin
				pend <= 1'b1;
				rd_idx <= rd_idx + 6'd1;   // Next word read ahead
				if (drain_p2)
					p2_req <= ~p2_req;
				else
					p1_req <= ~p1_req;
			end
		end
	end

	// Block base is taken at its last byte, 63 words back
	always_ff @(posedge CLK_48M) begin
		if (blk_last)
			wr_addr <= region >= REG_V1 ? p2_addr - 25'd63 : {2'b00, p1_addr - 23'd63};
		else if (pend && ack_ok)
			wr_addr <= wr_addr + 25'd1;
		if (busy && !pend)
			wr_data <= rd_data;
	end

	assign p1_wr = '{req: p1_req, addr: wr_addr[22:0], data: wr_data};
	assign p2_wr = '{req: p2_req, addr: wr_addr, data: wr_data};

	a_p1_hold: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		p1_req != p1_ack |=> $stable(p1_req));
	a_p2_hold: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		p2_req != p2_ack |=> $stable(p2_req));

endmodule

`default_nettype wire

//--- hw/neo_cart_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "neo_cart_defs.svh"

module neo_cart_loader (
	input  wire                       CLK_48M,
	input  wire                       pll_locked,
	input  wire neo_cart_pkg::ioctl_t ioctl,
	input  wire                       p1_ack,
	input  wire                       p2_ack,
	output neo_cart_pkg::p1_wr_t      p1_wr,
	output neo_cart_pkg::p2_wr_t      p2_wr
);
	import neo_cart_pkg::*;

	region_e                region;
	logic [`NEO_ADDR_W-1:0] offset;
	sizes_t                 sizes;
	logic [31:0]            region_size;
	logic                   pcm_merged;
	logic                   fill_en;
	logic                   page_full;
	logic [5:0]             rd_idx;
	logic [15:0]            rd_data;
	logic [22:0]            p1_addr;
	logic [24:0]            p2_addr;

	load_ctrl ctrl_i (
		.CLK_48M     (CLK_48M),
		.pll_locked  (pll_locked),
		.ioctl       (ioctl),
		.region_size (region_size),
		.page_full   (page_full),
		.rd_data     (rd_data),
		.p1_addr     (p1_addr),
		.p2_addr     (p2_addr),
		.p1_ack      (p1_ack),
		.p2_ack      (p2_ack),
		.region      (region),
		.offset      (offset),
		.fill_en     (fill_en),
		.rd_idx      (rd_idx),
		.p1_wr       (p1_wr),
		.p2_wr       (p2_wr)
	);

	neo_header hdr_i (
		.CLK_48M     (CLK_48M),
		.pll_locked  (pll_locked),
		.ioctl       (ioctl),
		.region      (region),
		.sizes       (sizes),
		.region_size (region_size),
		.pcm_merged  (pcm_merged)
	);

	tile_fifo fifo_i (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.ioctl      (ioctl),
		.fill_en    (fill_en),
		.region     (region),
		.rd_idx     (rd_idx),
		.page_full  (page_full),
		.rd_data    (rd_data)
	);

	sdram_addr_map map_i (
		.region     (region),
		.offset     (offset),
		.sizes      (sizes),
		.pcm_merged (pcm_merged),
		.p1_addr    (p1_addr),
		.p2_addr    (p2_addr)
	);

endmodule

`default_nettype wire

//--- sim/tb_neo_cart_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "neo_cart_defs.svh"

module tb_neo_cart_loader;
	import neo_cart_pkg::*;

	logic        CLK_48M;
	logic        pll_locked;
	ioctl_t      ioctl;
	logic        p1_ack = 1'b0;
	logic        p2_ack = 1'b0;
	p1_wr_t      p1_wr;
	p2_wr_t      p2_wr;

	logic [31:0] gold [0:27];   // sizes, block count, word total, then 4 words per block
	integer      seed = 51365;
	int          cycles = 0;
	int          limit = 0;
	int          img_bytes;
	int          words = 0;
	int          p1_words = 0;
	int          p2_words = 0;
	logic        p1_req_q = 1'b0;
	logic        p2_req_q = 1'b0;
	logic        p1_ack_q = 1'b0;
	logic        p2_ack_q = 1'b0;
	p1_wr_t      p1_last;
	p2_wr_t      p2_last;

	neo_cart_loader dut_i (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.ioctl      (ioctl),
		.p1_ack     (p1_ack),
		.p2_ack     (p2_ack),
		.p1_wr      (p1_wr),
		.p2_wr      (p2_wr)
	);

	initial begin
		CLK_48M = 1'b0;
		forever #4 CLK_48M = ~CLK_48M;
	end

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic value_error(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("error t=%0t %s got %h exp %h", $time, name, got, exp);
		abort_run();
	endtask

	task automatic check_p1(input p1_wr_t got, input p1_wr_t exp, input bit with_data);
		if (got.req !== exp.req)
			value_error("p1_wr.req", 32'(got.req), 32'(exp.req));
		if (got.addr !== exp.addr)
			value_error("p1_wr.addr", 32'(got.addr), 32'(exp.addr));
		if (with_data && got.data !== exp.data)
			value_error("p1_wr.data", 32'(got.data), 32'(exp.data));
	endtask

	task automatic check_p2(input p2_wr_t got, input p2_wr_t exp, input bit with_data);
		if (got.req !== exp.req)
			value_error("p2_wr.req", 32'(got.req), 32'(exp.req));
		if (got.addr !== exp.addr)
			value_error("p2_wr.addr", 32'(got.addr), 32'(exp.addr));
		if (with_data && got.data !== exp.data)
			value_error("p2_wr.data", 32'(got.data), 32'(exp.data));
	endtask

	task automatic check_count(input int got, input int exp, input string name);
		if (got !== exp)
			value_error(name, 32'(got), 32'(exp));
	endtask

	task automatic check_sizes(input sizes_t got, input sizes_t exp);
		for (int f = 0; f < 6; f++)
			if (got[f*32 +: 32] !== exp[f*32 +: 32])
				value_error($sformatf("sizes field %0d", f), got[f*32 +: 32], exp[f*32 +: 32]);
	endtask

	// Size fields little endian from byte 4, the rest is a counting pattern
	function automatic logic [7:0] image_byte(input int a);
		int f;
		f = (a - `NEO_SIZE_FIRST) / 4;
		if (a >= `NEO_SIZE_FIRST && a <= `NEO_SIZE_LAST)
			return 8'(gold[f] >> (8 * ((a - `NEO_SIZE_FIRST) % 4)));
		return 8'(a % 251);
	endfunction

	// Top bit says whether the data word is known
	function automatic logic [16:0] word_rule(input int b, input int i);
		int a;
		a = `NEO_HDR_BYTES + b * `NEO_BLOCK + 2 * i;
		if (i == 0)
			return {1'b1, gold[10 + 4*b][15:0]};
		if (i == 63)
			return {1'b1, gold[11 + 4*b][15:0]};
		if (b * `NEO_BLOCK < int'(gold[0]))   // P keeps plain byte order
			return {1'b1, image_byte(a + 1), image_byte(a)};
		return {1'b0, 16'h0000};
	endfunction

	task automatic check_block(input int port);
		int b;
		b = words / 64;
		if (b >= int'(gold[6])) begin
			$display("write on port %0d past the last expected block at t=%0t", port, $time);
			abort_run();
		end
		if (int'(gold[8 + 4*b]) != port) begin
			$display("block %0d written on port %0d instead of port %0d", b, port, gold[8 + 4*b]);
			abort_run();
		end
	endtask

	// Request monitor, sampled away from the rising edge
	always @(negedge CLK_48M) begin
		p1_wr_t      e1;
		p2_wr_t      e2;
		logic [16:0] rule;
		if (pll_locked) begin
			if (p1_wr.req != p1_req_q) begin
				if (p1_req_q != p1_ack_q) begin
					$display("p1 req toggled while the previous request was outstanding");
					abort_run();
				end
				check_block(1);
				rule = word_rule(words / 64, words % 64);
				e1.req = ~p1_req_q;
				e1.addr = 23'(gold[9 + 4*(words / 64)] + 32'(words % 64));
				e1.data = rule[15:0];
				check_p1(p1_wr, e1, rule[16]);
				p1_last = p1_wr;
				words++;
				p1_words++;
			end else if (p1_wr.req != p1_ack) begin
				check_p1(p1_wr, p1_last, 1'b1);   // held while waiting
			end
			if (p2_wr.req != p2_req_q) begin
				if (p2_req_q != p2_ack_q) begin
					$display("p2 req toggled while the previous request was outstanding");
					abort_run();
				end
				check_block(2);
				rule = word_rule(words / 64, words % 64);
				e2.req = ~p2_req_q;
				e2.addr = 25'(gold[9 + 4*(words / 64)] + 32'(words % 64));
				e2.data = rule[15:0];
				check_p2(p2_wr, e2, rule[16]);
				p2_last = p2_wr;
				words++;
				p2_words++;
			end else if (p2_wr.req != p2_ack) begin
				check_p2(p2_wr, p2_last, 1'b1);
			end
		end
		p1_req_q = p1_wr.req;
		p2_req_q = p2_wr.req;
		p1_ack_q = p1_ack;
		p2_ack_q = p2_ack;
	end

	// SDRAM side, answers after 0 to 6 cycles
	always begin
		int delay;
		@(posedge CLK_48M);
		#1;
		if (p1_wr.req != p1_ack || p2_wr.req != p2_ack) begin
			delay = {$random(seed)} % 7;
			repeat (delay) @(posedge CLK_48M);
			if (delay > 0)
				#1;
			p1_ack = p1_wr.req;
			p2_ack = p2_wr.req;
		end
	end

	always @(posedge CLK_48M) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: the load did not finish within %0d cycles", limit);
			abort_run();
		end
	end

	initial begin
		int     a;
		int     exp_p1;
		logic   p1_end;
		logic   p2_end;
		sizes_t exp_sizes;
		pll_locked = 1'b0;
		ioctl = '0;
		$readmemh("sim/cart_golden.txt", gold);
		img_bytes = `NEO_HDR_BYTES;
		for (int f = 0; f < 6; f++)
			img_bytes += int'(gold[f]);
		limit = 12 * img_bytes + 2000;
		exp_sizes = {gold[5], gold[4], gold[3], gold[2], gold[1], gold[0]};

		repeat (8) @(posedge CLK_48M);
		#1;
		pll_locked = 1'b1;
		check_count(int'(p1_wr.req), 0, "p1_wr.req after reset");
		check_count(int'(p2_wr.req), 0, "p2_wr.req after reset");
		repeat (4) @(posedge CLK_48M);
		#1;
		ioctl.downl = 1'b1;

		for (a = 0; a < img_bytes; a++) begin
			@(posedge CLK_48M);
			#1;
			ioctl.wr = 1'b1;
			ioctl.addr = 27'(a);
			ioctl.dout = image_byte(a);
			@(posedge CLK_48M);
			#1;
			ioctl.wr = 1'b0;
			repeat (6) @(posedge CLK_48M);
			if (a == `NEO_HDR_BYTES - 1) begin
				check_sizes(dut_i.sizes, exp_sizes);
				check_count(int'(dut_i.pcm_merged), (gold[4] == 32'd0) ? 1 : 0, "pcm_merged");
				check_count(words, 0, "words written during the header");
			end
		end

		while (words < int'(gold[7]))
			@(posedge CLK_48M);
		p1_end = p1_wr.req;
		p2_end = p2_wr.req;
		repeat (64) @(posedge CLK_48M);
		#1;
		ioctl.downl = 1'b0;
		repeat (16) @(posedge CLK_48M);

		check_count(int'(p1_wr.req), int'(p1_end), "p1_wr.req after the image");
		check_count(int'(p2_wr.req), int'(p2_end), "p2_wr.req after the image");
		check_count(words, int'(gold[7]), "total word count");
		exp_p1 = 0;
		for (int b = 0; b < int'(gold[6]); b++)
			if (gold[8 + 4*b] == 32'd1)
				exp_p1 += 64;
		check_count(p1_words, exp_p1, "port 1 word count");
		check_count(p2_words, int'(gold[7]) - exp_p1, "port 2 word count");

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/cart_golden.txt
// sizes in bytes P S M V1 V2 C, then block count and total word count
// per block: port, first word address, first data word, last data word
00000100 00000080 00000000 00000080 00000000 00000080
00000005 00000140
// P, two blocks of plain data
00000001 00000000 00005150 0000CFCE
00000001 00000040 0000D1D0 00005453
// S with the fix prefix and fix tile order
00000001 00700000 00006D65 0000C4BC
// V1 placed after the C size
00000002 00000040 0000D6D5 00005958
// C from the bottom in sprite tile order
00000002 00000000 00009C9A 00009997

//--- list.f
+incdir+hw
hw/neo_cart_pkg.sv
hw/sdram_addr_map.sv
hw/neo_header.sv
hw/tile_fifo.sv
hw/load_ctrl.sv
hw/neo_cart_loader.sv
sim/tb_neo_cart_loader.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_neo_cart_loader \
	-f list.f -o tb_neo_cart_loader
out=$(./obj_dir/tb_neo_cart_loader || true)
echo "$out"
echo "$out" | grep -qx '>>> PASS'
